// ==== source/bch_gf_pkg.sv ====
//********************
// gf(2^5) arithmetic and bch(31,21) code constants
// shared by the encoder, the syndrome calculator and the chien search
//********************

package bch_gf_pkg;

  // code geometry, dec bch over gf(2^5)
  localparam int GF_M     = 5;
  localparam int CW_LEN   = 31;
  localparam int DATA_LEN = 21;
  localparam int ECC_LEN  = 10;

  // x^5 + x^2 + 1
  localparam logic [GF_M:0] PRIM_POLY = 6'b100101;
  // m1(x) * m3(x) = x^10 + x^9 + x^8 + x^6 + x^5 + x^3 + 1
  localparam logic [ECC_LEN:0] GEN_POLY = 11'b111_0110_1001;

  typedef logic [GF_M-1:0] gf_elem_t;

  // fixed field elements, polynomial basis
  localparam gf_elem_t GF_ONE       = 5'b00001;
  localparam gf_elem_t GF_ALPHA     = 5'b00010;
  localparam gf_elem_t GF_ALPHA3    = 5'b01000;
  // alpha^30, i.e. alpha^-1
  localparam gf_elem_t GF_ALPHA_INV = 5'b10010;

  typedef struct packed {
    gf_elem_t s1;
    gf_elem_t s3;
  } synd_t;

  // carry-less product, then fold the top bits back by prim poly
  function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
    logic [2*GF_M-2:0] prod;
    logic [2*GF_M-2:0] aa;
    logic [2*GF_M-2:0] pp;
    prod = '0;
    aa = '0;
    pp = '0;
    aa[GF_M-1:0] = a;
    pp[GF_M:0] = PRIM_POLY;
    for (int i = 0; i < GF_M; i++) begin
      if (b[i]) prod ^= aa << i;
    end
    for (int i = 2*GF_M-2; i >= GF_M; i--) begin
      if (prod[i]) prod ^= pp << (i - GF_M);
    end
    return prod[GF_M-1:0];
  endfunction

  function automatic gf_elem_t gf_sq(input gf_elem_t a);
    return gf_mul(a, a);
  endfunction

  // a^-1 = a^30 = a^16 * a^8 * a^4 * a^2, zero maps to zero
  function automatic gf_elem_t gf_inv(input gf_elem_t a);
    gf_elem_t a2;
    gf_elem_t a4;
    gf_elem_t a8;
    gf_elem_t a16;
    a2  = gf_sq(a);
    a4  = gf_sq(a2);
    a8  = gf_sq(a4);
    a16 = gf_sq(a8);
    return gf_mul(gf_mul(a16, a8), gf_mul(a4, a2));
  endfunction

endpackage

// ==== source/bch_codec_pkg.sv ====
//********************
// codec transaction types
// codeword view, request and response words, operation code
//********************

package bch_codec_pkg;

  import bch_gf_pkg::*;

  // operation carried by each request
  typedef enum logic {
    OP_ENCODE = 1'b0,
    OP_DECODE = 1'b1
  } bch_op_e;

  // systematic split, data on top, parity below
  typedef struct packed {
    logic [DATA_LEN-1:0] data;
    logic [ECC_LEN-1:0]  ecc;
  } cw_fields_t;

  // one 31 bit word, seen flat or split
  // raw bit k is the coefficient of x^k
  typedef union packed {
    logic [CW_LEN-1:0] raw;
    cw_fields_t        fields;
  } codeword_u;

  // request, 32 bits
  // ecc field is don't care for encode
  typedef struct packed {
    bch_op_e   op;
    codeword_u cw;
  } bch_req_t;

  // response, 33 bits
  // encode: data echoed plus new parity
  // decode: corrected word and status
  typedef struct packed {
    codeword_u cw;
    logic      err_det;
    logic      uncorr;
  } bch_rsp_t;

endpackage

// ==== source/bch_parity_gen.sv ====
//********************
// bch(31,21) systematic parity generator
// remainder of data * x^10 modulo the generator polynomial
//********************

`timescale 1ns/1ps

module bch_parity_gen import bch_gf_pkg::*; (
  input  logic [DATA_LEN-1:0] data_i,
  output logic [ECC_LEN-1:0]  ecc_o
);

  //********************
  // unrolled lfsr division
  //********************

  always_comb begin
    logic [ECC_LEN-1:0] rem;
    logic               fb;
    rem = '0;
    // msb first, data bit i sits at x^(i+10)
    for (int i = DATA_LEN-1; i >= 0; i--) begin
      // feedback from top of remainder
      fb  = data_i[i] ^ rem[ECC_LEN-1];
      rem = {rem[ECC_LEN-2:0], 1'b0};
      // subtract g(x), leading term implied
      if (fb) begin
        rem ^= GEN_POLY[ECC_LEN-1:0];
      end
    end
    // remainder is the parity word
    ecc_o = rem;
  end

  // note: {data, ecc} is a multiple of g(x), so both syndromes vanish

endmodule

// ==== source/bch_syndrome_calc.sv ====
//********************
// bch(31,21) syndrome calculator
// r(alpha) and r(alpha^3), purely combinational
//********************

`timescale 1ns/1ps

module bch_syndrome_calc import bch_gf_pkg::*, bch_codec_pkg::*; (
  input  codeword_u cw_i,
  output synd_t     synd_o
);

  //********************
  // power sums
  //********************

  // running powers alpha^k and alpha^3k
  // constant per k, so each set bit costs only xor gates
  always_comb begin
    gf_elem_t p1;
    gf_elem_t p3;
    gf_elem_t s1;
    gf_elem_t s3;
    p1 = GF_ONE;
    p3 = GF_ONE;
    s1 = '0;
    s3 = '0;
    for (int k = 0; k < CW_LEN; k++) begin
      // add this position's field powers when the bit is set
      if (cw_i.raw[k]) begin
        s1 ^= p1;
        s3 ^= p3;
      end
      // step to position k+1
      p1 = gf_mul(p1, GF_ALPHA);
      p3 = gf_mul(p3, GF_ALPHA3);
    end
    synd_o.s1 = s1;
    synd_o.s3 = s3;
  end

  // note: s2 and s4 are squares of s1 in binary bch, not needed

endmodule

// ==== source/bch_chien_search.sv ====
//********************
// dec locator and chien search for bch(31,21)
// error mask and uncorrectable flag, registered on en_i
//********************

`timescale 1ns/1ps

module bch_chien_search import bch_gf_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              en_i,
  input  synd_t             synd_i,
  output logic [CW_LEN-1:0] msk_o,
  output logic              uncorr_o
);

  // sigma(x) = 1 + c1 x + c2 x^2
  gf_elem_t          c1;
  gf_elem_t          c2;
  // expected number of roots
  logic [GF_M-1:0]   deg;
  logic [GF_M-1:0]   n_roots;
  logic [CW_LEN-1:0] roots;
  logic [CW_LEN-1:0] msk_d;
  logic              uncorr_d;

  //********************
  // locator coefficients
  //********************

  // c2 is zero when s3 == s1^3, single error case
  assign c1 = synd_i.s1;
  assign c2 = gf_sq(synd_i.s1) ^ gf_mul(synd_i.s3, gf_inv(synd_i.s1));

  always_comb begin
    if (synd_i.s1 == '0) begin
      deg = '0;
    end else if (c2 == '0) begin
      deg = GF_M'(1);
    end else begin
      deg = GF_M'(2);
    end
  end

  //********************
  // search over 31 positions
  //********************

  // position k is in error when sigma(alpha^-k) == 0
  always_comb begin
    gf_elem_t x;
    gf_elem_t val;
    x       = GF_ONE;
    roots   = '0;
    n_roots = '0;
    for (int k = 0; k < CW_LEN; k++) begin
      val = GF_ONE ^ gf_mul(c1, x) ^ gf_mul(c2, gf_sq(x));
      if (val == '0) begin
        roots[k] = 1'b1;
        n_roots  = n_roots + 1'b1;
      end
      x = gf_mul(x, GF_ALPHA_INV);
    end
  end

  // s1 zero with s3 set, or root count short of degree
  assign uncorr_d = ((synd_i.s1 == '0) && (synd_i.s3 != '0)) || (n_roots != deg);
  // no partial correction on failure
  assign msk_d    = uncorr_d ? '0 : roots;

  // capture stage, same clk/en timing as a rom lookup
  always_ff @(posedge clk) begin
    if (rst_i) begin
      msk_o    <= '0;
      uncorr_o <= 1'b0;
    end else if (en_i) begin
      msk_o    <= msk_d;
      uncorr_o <= uncorr_d;
    end
  end

endmodule

// ==== source/bch_decoder.sv ====
//********************
// dec bch(31,21) decoder top
// syndromes into chien search, mask and flags one cycle after en_i
//********************

`timescale 1ns/1ps

module bch_decoder import bch_gf_pkg::*, bch_codec_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              en_i,
  input  codeword_u         cw_i,
  output logic [CW_LEN-1:0] msk_o,
  output logic              err_det_o,
  output logic              uncorr_o
);

  // s1 and s3 of the received word
  synd_t synd;

  // combinational syndromes
  bch_syndrome_calc syndrome_calc_i (
    .cw_i   (cw_i),
    .synd_o (synd)
  );

  // locator solve, registered on en_i
  bch_chien_search chien_search_i (
    .clk      (clk),
    .rst_i    (rst_i),
    .en_i     (en_i),
    .synd_i   (synd),
    .msk_o    (msk_o),
    .uncorr_o (uncorr_o)
  );

  //********************
  // error detect
  //********************

  // any nonzero syndrome, kept in step with the mask
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_det_o <= 1'b0;
    end else if (en_i) begin
      err_det_o <= |synd;
    end
  end

endmodule

// ==== source/bch_codec.sv ====
//********************
// bch(31,21) codec with four-phase req/ack port
// encode or decode one request, response 3 edges after req
//********************

`timescale 1ns/1ps

module bch_codec import bch_gf_pkg::*, bch_codec_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     req_i,
  input  bch_req_t req_data_i,
  output logic     ack_o,
  output bch_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ACK
  } state_e;

  state_e            state_q;
  // decoder enable, high for the first wait cycle
  logic              dec_en_q;
  bch_req_t          req_q;
  logic [ECC_LEN-1:0] enc_ecc;
  logic [CW_LEN-1:0] dec_msk;
  logic              dec_err_det;
  logic              dec_uncorr;
  bch_rsp_t          rsp_d;

  bch_parity_gen parity_gen_i (
    .data_i (req_q.cw.fields.data),
    .ecc_o  (enc_ecc)
  );

  bch_decoder decoder_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .en_i      (dec_en_q),
    .cw_i      (req_q.cw),
    .msk_o     (dec_msk),
    .err_det_o (dec_err_det),
    .uncorr_o  (dec_uncorr)
  );

  // request capture when a new transaction starts
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && req_i) begin
      req_q <= req_data_i;
    end
  end

  // response select
  always_comb begin
    rsp_d = '0;
    if (req_q.op == OP_DECODE) begin
      // flip the located bits
      rsp_d.cw.raw  = req_q.cw.raw ^ dec_msk;
      rsp_d.err_det = dec_err_det;
      rsp_d.uncorr  = dec_uncorr;
    end else begin
      rsp_d.cw.fields.data = req_q.cw.fields.data;
      rsp_d.cw.fields.ecc  = enc_ecc;
    end
  end

  //********************
  // handshake fsm
  //********************

  // idle -> wait (en) -> wait -> ack, encode runs the same schedule
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      dec_en_q <= 1'b0;
      rsp_o    <= '0;
    end else begin
      dec_en_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q  <= ST_WAIT;
            dec_en_q <= 1'b1;
          end
        end
        // second wait cycle, decoder outputs now valid
        ST_WAIT: begin
          if (!dec_en_q) begin
            state_q <= ST_ACK;
            rsp_o   <= rsp_d;
          end
        end
        // hold until requester drops req
        ST_ACK: begin
          if (!req_i) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign ack_o = (state_q == ST_ACK);

endmodule

// ==== tests/bch_codec_asserts.sv ====
//********************
// handshake and reset assertions for the bch codec
// bound into bch_codec from the testbench
//********************

`timescale 1ns/1ps

module bch_codec_asserts import bch_codec_pkg::*; (
  input logic     clk,
  input logic     rst_i,
  input logic     req_i,
  input logic     ack_o,
  input bch_rsp_t rsp_o
);

  // number of failed properties so far
  int fail_cnt = 0;

  // reset clears ack
  ack_after_rst: assert property (@(posedge clk) rst_i |=> !ack_o)
    else begin
      fail_cnt++;
      $error("ack_o high in the cycle after reset");
    end

  // req sampled high at edge 0 gives ack at edge 3
  ack_latency: assert property (@(posedge clk) disable iff (rst_i)
    $rose(req_i) |-> ##3 $rose(ack_o))
    else begin
      fail_cnt++;
      $error("ack_o did not rise 3 edges after req_i");
    end

  // four-phase hold
  ack_hold: assert property (@(posedge clk) disable iff (rst_i)
    ack_o && req_i |=> ack_o)
    else begin
      fail_cnt++;
      $error("ack_o dropped while req_i still high");
    end

  // response frozen while acknowledged
  rsp_stable: assert property (@(posedge clk) disable iff (rst_i)
    ack_o |=> !ack_o || $stable(rsp_o))
    else begin
      fail_cnt++;
      $error("rsp_o changed while ack_o high");
    end

endmodule

// ==== tests/bch_codec_tb.sv ====
//********************
// bch(31,21) codec testbench
// directed encode, clean, single and double error decode
//********************

`timescale 1ns/1ps

module bch_codec_tb
  import bch_gf_pkg::*, bch_codec_pkg::*;
();

  // clocks allowed for any ack edge
  localparam int ACK_TIMEOUT = 20;

  logic     clk = 1'b0;
  logic     rst_i;
  logic     req_i;
  bch_req_t req_data_i;
  logic     ack_o;
  bch_rsp_t rsp_o;
  integer   seed;

  bch_codec bch_codec_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  // protocol checks inside the dut
  bind bch_codec bch_codec_asserts asserts_i (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (req_i),
    .ack_o (ack_o),
    .rsp_o (rsp_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //********************
  // failure and compare
  //********************

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_cw(input string name, input codeword_u got, input codeword_u exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got %h expected %h", name, got.raw, exp.raw));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rsp(input bch_rsp_t got, input bch_rsp_t exp);
    check_cw("rsp_o.cw", got.cw, exp.cw);
    check_flag("rsp_o.err_det", got.err_det, exp.err_det);
    check_flag("rsp_o.uncorr", got.uncorr, exp.uncorr);
  endtask

  //********************
  // reference model
  //********************

  // long division of d(x) x^10 by g(x) leaves the parity
  function automatic codeword_u model_cw(input logic [DATA_LEN-1:0] data);
    logic [CW_LEN-1:0] poly;
    codeword_u         cw;
    poly = {data, {ECC_LEN{1'b0}}};
    for (int i = CW_LEN-1; i >= ECC_LEN; i--) begin
      if (poly[i]) poly ^= CW_LEN'(GEN_POLY) << (i - ECC_LEN);
    end
    cw.fields.data = data;
    cw.fields.ecc  = poly[ECC_LEN-1:0];
    return cw;
  endfunction

  function automatic logic [DATA_LEN-1:0] rand_data();
    logic [31:0] r;
    r = $random(seed);
    return r[DATA_LEN-1:0];
  endfunction

  //********************
  // handshake driver
  //********************

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    // sample away from the driving edge
    while (ack_o !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) stop_run($sformatf("timeout waiting for ack_o == %0d", level));
    end
  endtask

  // full four-phase cycle
  // hold counts extra cycles with req kept high
  task automatic run_txn(input bch_req_t req, input int hold, output bch_rsp_t rsp);
    @(posedge clk);
    req_i      <= 1'b1;
    req_data_i <= req;
    wait_ack(1'b1);
    rsp = rsp_o;
    repeat (hold) begin
      @(negedge clk);
      check_flag("ack_o", ack_o, 1'b1);
    end
    @(posedge clk);
    req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic encode_check(input logic [DATA_LEN-1:0] data);
    bch_req_t req;
    bch_rsp_t got;
    bch_rsp_t exp;
    req.op             = OP_ENCODE;
    req.cw.fields.data = data;
    // junk in the ignored parity field
    req.cw.fields.ecc  = ECC_LEN'($random(seed));
    run_txn(req, 0, got);
    exp    = '0;
    exp.cw = model_cw(data);
    check_rsp(got, exp);
  endtask

  task automatic decode_check(input codeword_u sent, input codeword_u orig, input logic err);
    bch_req_t req;
    bch_rsp_t got;
    bch_rsp_t exp;
    req.op = OP_DECODE;
    req.cw = sent;
    run_txn(req, 0, got);
    exp.cw      = orig;
    exp.err_det = err;
    exp.uncorr  = 1'b0;
    check_rsp(got, exp);
  endtask

  //********************
  // directed tests
  //********************

  task automatic test_handshake();
    bch_req_t req;
    bch_rsp_t got;
    @(negedge clk);
    check_flag("ack_o", ack_o, 1'b0);
    req = '0;
    run_txn(req, 3, got);
    // no new ack without a new request
    @(negedge clk);
    check_flag("ack_o", ack_o, 1'b0);
  endtask

  task automatic test_encode();
    encode_check('0);
    encode_check('1);
    // walking one across the data field
    for (int i = 0; i < DATA_LEN; i++) encode_check(DATA_LEN'(1) << i);
    repeat (20) encode_check(rand_data());
  endtask

  task automatic test_clean_decode();
    codeword_u cw;
    cw = model_cw('0);
    decode_check(cw, cw, 1'b0);
    repeat (10) begin
      cw = model_cw(rand_data());
      decode_check(cw, cw, 1'b0);
    end
  endtask

  task automatic test_single_error();
    codeword_u cw;
    codeword_u bad;
    cw = model_cw(rand_data());
    for (int k = 0; k < CW_LEN; k++) begin
      bad = cw;
      bad.raw[k] = ~bad.raw[k];
      decode_check(bad, cw, 1'b1);
    end
  endtask

  task automatic test_double_error();
    codeword_u   cw;
    codeword_u   bad;
    logic [31:0] r;
    int          i;
    int          j;
    repeat (30) begin
      cw = model_cw(rand_data());
      r  = $random(seed);
      i  = int'(r % 31);
      r  = $random(seed);
      // offset 1..30 keeps the pair distinct
      j  = (i + 1 + int'(r % 30)) % CW_LEN;
      bad = cw;
      bad.raw[i] = ~bad.raw[i];
      bad.raw[j] = ~bad.raw[j];
      decode_check(bad, cw, 1'b1);
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    req_i      = 1'b0;
    req_data_i = '0;
    seed       = 32'h4832774e;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    test_handshake();
    test_encode();
    test_clean_decode();
    test_single_error();
    test_double_error();
    if (bch_codec_i.asserts_i.fail_cnt != 0) begin
      $display("Done: errors found");
      $fatal(1, "protocol assertion failed during the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== all.f ====
source/bch_gf_pkg.sv
source/bch_codec_pkg.sv
source/bch_parity_gen.sv
source/bch_syndrome_calc.sv
source/bch_chien_search.sv
source/bch_decoder.sv
source/bch_codec.sv
tests/bch_codec_asserts.sv
tests/bch_codec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bch_codec_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
